//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= ex_stage_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/ex_stage_props.sv
`timescale 1ns/1ps

module ex_stage_props (
  input logic clk,
  input logic rst_n,
  input logic mult_ready_i,
  input logic ex_valid_i,
  input logic wb_ready_i,
  input logic lsu_ready_ex_i,
  input logic regfile_we_wb_i
);

  // High multiply stalls the stage for one cycle only
  a_mult_single_stall : assert property (
    @(posedge clk) disable iff (!rst_n) !mult_ready_i |=> mult_ready_i
  ) else $error("multiplier held ready low for two cycles");

  // Valid only when both consumers can take the result
  a_valid_needs_ready : assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid_i |-> (wb_ready_i && lsu_ready_ex_i)
  ) else $error("ex_valid high while WB or LSU not ready");

  // Idle ready cycle flushes the load slot
  a_wb_flush : assert property (
    @(posedge clk) disable iff (!rst_n) (wb_ready_i && !ex_valid_i) |=> !regfile_we_wb_i
  ) else $error("write-back enable not cleared after idle cycle");

endmodule

bind ex_stage ex_stage_props u_props (
  .clk             (clk),
  .rst_n           (rst_n),
  .mult_ready_i    (mult_ready),
  .ex_valid_i      (ex_valid_o),
  .wb_ready_i      (wb_ready_i),
  .lsu_ready_ex_i  (lsu_ready_ex_i),
  .regfile_we_wb_i (regfile_we_wb_o)
);

//--- dv/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

  localparam int CLK_NS    = 40;
  localparam int SETTLE_NS = 10;
  localparam int ROUNDS    = 4;
  // Reset, ALU sweep, branches, multiplier, then the short directed tests
  localparam int TEST_CYCLES     = 8 + 16 * ROUNDS + 6 * ROUNDS + 7 * ROUNDS + 3 + 24;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

  logic            clk;
  logic            rst_n;
  logic            alu_en;
  ex_pkg::alu_op_e alu_operator;
  ex_pkg::data_t   alu_operand_a;
  ex_pkg::data_t   alu_operand_b;
  ex_pkg::data_t   alu_operand_c;
  logic            mult_en;
  ex_pkg::mul_op_e mult_operator;
  ex_pkg::data_t   mult_operand_a;
  ex_pkg::data_t   mult_operand_b;
  logic            csr_access;
  ex_pkg::data_t   csr_rdata;
  logic            lsu_en;
  ex_pkg::data_t   lsu_rdata;
  logic            lsu_ready_ex;
  logic            lsu_err;
  logic            branch_in_ex;
  logic            wb_ready;
  logic            regfile_alu_we;
  ex_pkg::raddr_t  regfile_alu_waddr;
  logic            regfile_we;
  ex_pkg::raddr_t  regfile_waddr;

  // DUT outputs
  ex_pkg::raddr_t  fw_waddr;
  logic            fw_we;
  logic            fw_we_power;
  ex_pkg::data_t   fw_wdata;
  ex_pkg::raddr_t  wb_waddr;
  logic            wb_we;
  logic            wb_we_power;
  ex_pkg::data_t   wb_wdata;
  logic            ex_ready;
  logic            ex_valid;
  logic            mult_multicycle;
  logic            branch_decision;
  ex_pkg::data_t   jump_target;

  logic [31:0]     rng_state;

  ex_stage #(
    .POWER_GATE (1)
  ) u_dut (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .alu_en_i                  (alu_en),
    .alu_operator_i            (alu_operator),
    .alu_operand_a_i           (alu_operand_a),
    .alu_operand_b_i           (alu_operand_b),
    .alu_operand_c_i           (alu_operand_c),
    .mult_en_i                 (mult_en),
    .mult_operator_i           (mult_operator),
    .mult_operand_a_i          (mult_operand_a),
    .mult_operand_b_i          (mult_operand_b),
    .csr_access_i              (csr_access),
    .csr_rdata_i               (csr_rdata),
    .lsu_en_i                  (lsu_en),
    .lsu_rdata_i               (lsu_rdata),
    .lsu_ready_ex_i            (lsu_ready_ex),
    .lsu_err_i                 (lsu_err),
    .branch_in_ex_i            (branch_in_ex),
    .wb_ready_i                (wb_ready),
    .regfile_alu_we_i          (regfile_alu_we),
    .regfile_alu_waddr_i       (regfile_alu_waddr),
    .regfile_we_i              (regfile_we),
    .regfile_waddr_i           (regfile_waddr),
    .regfile_alu_waddr_fw_o    (fw_waddr),
    .regfile_alu_we_fw_o       (fw_we),
    .regfile_alu_we_fw_power_o (fw_we_power),
    .regfile_alu_wdata_fw_o    (fw_wdata),
    .regfile_waddr_wb_o        (wb_waddr),
    .regfile_we_wb_o           (wb_we),
    .regfile_we_wb_power_o     (wb_we_power),
    .regfile_wdata_wb_o        (wb_wdata),
    .ex_ready_o                (ex_ready),
    .ex_valid_o                (ex_valid),
    .mult_multicycle_o         (mult_multicycle),
    .branch_decision_o         (branch_decision),
    .jump_target_o             (jump_target)
  );

  //////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("Watchdog expired before the tests finished");
    $display("Test FAILED");
    $fatal(1);
  end

  //////////////////////////////////////////////////
  // Stimulus source and reference models
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // RISC-V compare semantics for SLT(U) and the branches
  function automatic logic cmp_model(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op)
      ex_pkg::ALU_SLT, ex_pkg::ALU_LT:   return $signed(a) < $signed(b);
      ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GE:                    return $signed(a) >= $signed(b);
      ex_pkg::ALU_GEU:                   return a >= b;
      ex_pkg::ALU_EQ:                    return a == b;
      ex_pkg::ALU_NE:                    return a != b;
      default:                           return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] alu_model(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      ex_pkg::ALU_ADD: return a + b;
      ex_pkg::ALU_SUB: return a - b;
      ex_pkg::ALU_AND: return a & b;
      ex_pkg::ALU_OR:  return a | b;
      ex_pkg::ALU_XOR: return a ^ b;
      ex_pkg::ALU_SLL: return a << b[4:0];
      ex_pkg::ALU_SRL: return a >> b[4:0];
      ex_pkg::ALU_SRA: return $signed(a) >>> b[4:0];
      default:         return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  // 64-bit product modulo 2**64 is exact for every sign mode
  function automatic logic [31:0] mul_model(input ex_pkg::mul_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (op == ex_pkg::MUL_H || op == ex_pkg::MUL_HSU) ? {{32{a[31]}}, a} : {32'b0, a};
    eb = (op == ex_pkg::MUL_H) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return (op == ex_pkg::MUL_L) ? p[31:0] : p[63:32];
  endfunction

  //////////////////////////////////////////////////
  // Checks and common drivers
  //////////////////////////////////////////////////

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic expect_flag(input logic got, input logic exp, input string what);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Nothing in EX and all consumers ready
  task automatic drive_idle();
    alu_en            = 1'b0;
    alu_operator      = ex_pkg::ALU_ADD;
    alu_operand_a     = '0;
    alu_operand_b     = '0;
    alu_operand_c     = '0;
    mult_en           = 1'b0;
    mult_operator     = ex_pkg::MUL_L;
    mult_operand_a    = '0;
    mult_operand_b    = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #SETTLE_NS;
    expect_flag(wb_we, 1'b0, "regfile_we_wb_o after reset");
    expect_flag(wb_we_power, 1'b0, "regfile_we_wb_power_o after reset");
    expect_flag(mult_multicycle, 1'b0, "mult_multicycle_o after reset");
    // Idle stage with a ready multiplier
    expect_flag(ex_ready, 1'b1, "ex_ready_o after reset");
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Directed tests start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic alu_results();
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     w;
    ex_pkg::alu_op_e op;
    for (int r = 0; r < ROUNDS; r++) begin
      for (int i = 0; i < 16; i++) begin
        op = ex_pkg::alu_op_e'(i[3:0]);
        next_rand(a);
        next_rand(b);
        next_rand(w);
        // Equal operands in the first round hit the EQ/GE corners
        if (r == 0 && i >= 8) b = a;
        alu_en            = 1'b1;
        alu_operator      = op;
        alu_operand_a     = a;
        alu_operand_b     = b;
        regfile_alu_we    = w[8];
        regfile_alu_waddr = w[5:0];
        #SETTLE_NS;
        check_word(fw_wdata, alu_model(op, a, b), "forwarding data");
        check_word(32'(fw_waddr), 32'(w[5:0]), "forwarding address");
        expect_flag(fw_we, w[8], "forwarding enable");
        @(negedge clk);
      end
    end
    drive_idle();
  endtask

  task automatic branch_outputs();
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    ex_pkg::alu_op_e op;
    for (int r = 0; r < ROUNDS; r++) begin
      for (int i = 10; i < 16; i++) begin
        op = ex_pkg::alu_op_e'(i[3:0]);
        next_rand(a);
        next_rand(b);
        next_rand(c);
        if (r[0]) b = a;
        alu_en        = 1'b1;
        alu_operator  = op;
        alu_operand_a = a;
        alu_operand_b = b;
        alu_operand_c = c;
        #SETTLE_NS;
        expect_flag(branch_decision, cmp_model(op, a, b), "branch_decision_o");
        check_word(jump_target, c, "jump_target_o");
        @(negedge clk);
      end
    end
    drive_idle();
  endtask

  task automatic mult_sequences();
    logic [31:0]     a;
    logic [31:0]     b;
    ex_pkg::mul_op_e op;
    for (int r = 0; r < ROUNDS; r++) begin
      next_rand(a);
      next_rand(b);
      mult_en        = 1'b1;
      mult_operator  = ex_pkg::MUL_L;
      mult_operand_a = a;
      mult_operand_b = b;
      #SETTLE_NS;
      check_word(fw_wdata, mul_model(ex_pkg::MUL_L, a, b), "low product");
      expect_flag(ex_ready, 1'b1, "ex_ready_o on MUL_L");
      expect_flag(mult_multicycle, 1'b0, "mult_multicycle_o on MUL_L");
      @(negedge clk);
      for (int k = 1; k < 4; k++) begin
        op = ex_pkg::mul_op_e'(k[1:0]);
        next_rand(a);
        next_rand(b);
        mult_operator  = op;
        mult_operand_a = a;
        mult_operand_b = b;
        // Stall cycle
        #SETTLE_NS;
        expect_flag(ex_ready, 1'b0, "ex_ready_o in first high cycle");
        expect_flag(mult_multicycle, 1'b1, "mult_multicycle_o in first high cycle");
        @(negedge clk);
        // Registered upper word
        #SETTLE_NS;
        expect_flag(ex_ready, 1'b1, "ex_ready_o in second high cycle");
        expect_flag(mult_multicycle, 1'b0, "mult_multicycle_o in second high cycle");
        check_word(fw_wdata, mul_model(op, a, b), "high product");
        @(negedge clk);
      end
    end
    // WB back-pressure in the second cycle keeps the upper word
    next_rand(a);
    next_rand(b);
    mult_en        = 1'b1;
    mult_operator  = ex_pkg::MUL_H;
    mult_operand_a = a;
    mult_operand_b = b;
    @(negedge clk);
    wb_ready       = 1'b0;
    mult_operand_a = ~a;
    mult_operand_b = ~b;
    #SETTLE_NS;
    expect_flag(ex_ready, 1'b0, "ex_ready_o with WB stalled");
    check_word(fw_wdata, mul_model(ex_pkg::MUL_H, a, b), "high product with WB stalled");
    @(negedge clk);
    wb_ready = 1'b1;
    #SETTLE_NS;
    expect_flag(ex_ready, 1'b1, "ex_ready_o after WB stall");
    expect_flag(mult_multicycle, 1'b0, "mult_multicycle_o after WB stall");
    check_word(fw_wdata, mul_model(ex_pkg::MUL_H, a, b), "held high product");
    @(negedge clk);
    drive_idle();
  endtask

  task automatic csr_priority();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    next_rand(a);
    next_rand(b);
    next_rand(c);
    csr_access     = 1'b1;
    csr_rdata      = c;
    mult_en        = 1'b1;
    mult_operator  = ex_pkg::MUL_L;
    mult_operand_a = a;
    mult_operand_b = b;
    alu_en         = 1'b1;
    alu_operator   = ex_pkg::ALU_XOR;
    alu_operand_a  = a;
    alu_operand_b  = c;
    #SETTLE_NS;
    check_word(fw_wdata, c, "CSR data over multiplier and ALU");
    @(negedge clk);
    csr_access = 1'b0;
    #SETTLE_NS;
    check_word(fw_wdata, mul_model(ex_pkg::MUL_L, a, b), "multiplier over ALU");
    @(negedge clk);
    drive_idle();
  endtask

  task automatic load_writeback();
    logic [31:0] d;
    logic [31:0] w;
    // Plain load
    next_rand(w);
    next_rand(d);
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = w[5:0];
    lsu_rdata     = d;
    #SETTLE_NS;
    expect_flag(ex_valid, 1'b1, "ex_valid_o on load");
    @(negedge clk);
    lsu_en        = 1'b0;
    regfile_we    = 1'b0;
    regfile_waddr = ~w[5:0];
    next_rand(d);
    lsu_rdata = d;
    #SETTLE_NS;
    expect_flag(wb_we, 1'b1, "regfile_we_wb_o after load");
    expect_flag(wb_we_power, 1'b1, "regfile_we_wb_power_o after load");
    check_word(32'(wb_waddr), 32'(w[5:0]), "write-back address");
    check_word(wb_wdata, d, "write-back data");
    // Idle ready cycle drains the slot
    @(negedge clk);
    #SETTLE_NS;
    expect_flag(wb_we, 1'b0, "regfile_we_wb_o after idle cycle");
    // Bus error on the load
    @(negedge clk);
    lsu_en     = 1'b1;
    regfile_we = 1'b1;
    lsu_err    = 1'b1;
    @(negedge clk);
    lsu_en     = 1'b0;
    regfile_we = 1'b0;
    lsu_err    = 1'b0;
    #SETTLE_NS;
    expect_flag(wb_we, 1'b0, "regfile_we_wb_o after bus error");
    // WB back-pressure holds the slot
    @(negedge clk);
    next_rand(w);
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = w[5:0];
    @(negedge clk);
    wb_ready      = 1'b0;
    regfile_waddr = ~w[5:0];
    #SETTLE_NS;
    expect_flag(ex_valid, 1'b0, "ex_valid_o with wb_ready_i low");
    expect_flag(wb_we_power, 1'b0, "regfile_we_wb_power_o with wb_ready_i low");
    @(negedge clk);
    #SETTLE_NS;
    expect_flag(wb_we, 1'b1, "regfile_we_wb_o held");
    check_word(32'(wb_waddr), 32'(w[5:0]), "held write-back address");
    @(negedge clk);
    drive_idle();
    @(negedge clk);
    #SETTLE_NS;
    expect_flag(wb_we, 1'b0, "regfile_we_wb_o after drain");
    @(negedge clk);
  endtask

  task automatic stage_control();
    alu_en         = 1'b1;
    alu_operator   = ex_pkg::ALU_ADD;
    regfile_alu_we = 1'b1;
    lsu_ready_ex   = 1'b0;
    #SETTLE_NS;
    expect_flag(ex_ready, 1'b0, "ex_ready_o with LSU busy");
    expect_flag(fw_we_power, 1'b0, "power-qualified forwarding enable with LSU busy");
    expect_flag(fw_we, 1'b1, "forwarding enable with LSU busy");
    expect_flag(ex_valid, 1'b0, "ex_valid_o with LSU busy");
    @(negedge clk);
    // A branch in EX never waits on the LSU
    branch_in_ex = 1'b1;
    #SETTLE_NS;
    expect_flag(ex_ready, 1'b1, "ex_ready_o with branch in EX");
    expect_flag(ex_valid, 1'b0, "ex_valid_o with branch in EX");
    @(negedge clk);
    drive_idle();
  endtask

  initial begin
    rng_state = 32'd54;
    drive_idle();
    apply_reset();
    alu_results();
    branch_outputs();
    mult_sequences();
    csr_priority();
    load_writeback();
    stage_control();
    $display("Test OK");
    $finish;
  end

endmodule

//--- sources.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
dv/ex_stage_props.sv
dv/ex_stage_tb.sv

//--- verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
  input  logic            alu_en_i,
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::data_t   operand_a_i,
  input  ex_pkg::data_t   operand_b_i,
  output ex_pkg::data_t   result_o,
  output logic            cmp_result_o
);

  // Adder path
  logic          is_sub;
  ex_pkg::data_t adder_op_b;
  ex_pkg::data_t adder_result;

  // Shifter path
  logic [4:0]    shamt;
  ex_pkg::data_t shift_result;

  // Comparator path
  logic          is_equal;
  logic          lt_signed;
  logic          lt_unsigned;
  logic          cmp_result;

  ex_pkg::data_t result;

  //////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////

  assign is_sub = (operator_i == ex_pkg::ALU_SUB);

  // Two's complement subtract, carry-in supplies the +1
  assign adder_op_b   = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_op_b + {{(ex_pkg::DATA_W-1){1'b0}}, is_sub};

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Only the low five bits of b count
  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_SLL: shift_result = operand_a_i << shamt;
      ex_pkg::ALU_SRA: shift_result = $signed(operand_a_i) >>> shamt;
      default:         shift_result = operand_a_i >> shamt;
    endcase
  end

  //////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////

  assign is_equal    = (operand_a_i == operand_b_i);
  assign lt_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign lt_unsigned = (operand_a_i < operand_b_i);

  // Shared by set-less-than and the branch unit
  always_comb begin
    case (operator_i)
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_LT:   cmp_result = lt_signed;
      ex_pkg::ALU_SLTU,
      ex_pkg::ALU_LTU:  cmp_result = lt_unsigned;
      ex_pkg::ALU_GE:   cmp_result = ~lt_signed;
      ex_pkg::ALU_GEU:  cmp_result = ~lt_unsigned;
      ex_pkg::ALU_EQ:   cmp_result = is_equal;
      ex_pkg::ALU_NE:   cmp_result = ~is_equal;
      default:          cmp_result = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result = adder_result;
      ex_pkg::ALU_AND:  result = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA:  result = shift_result;
      // Comparisons return the flag zero-extended
      default:          result = {{(ex_pkg::DATA_W-1){1'b0}}, cmp_result};
    endcase
  end

  // Idle ALU drives zeros
  assign result_o     = alu_en_i ? result : '0;
  assign cmp_result_o = alu_en_i & cmp_result;

endmodule

//--- verilog/ex_mult.sv
`timescale 1ns/1ps

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::data_t   op_a_i,
  input  ex_pkg::data_t   op_b_i,
  input  logic            ex_ready_i,
  output ex_pkg::data_t   result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  typedef enum logic {
    IDLE,
    STEP
  } mulh_state_e;

  mulh_state_e state_q;
  mulh_state_e state_d;

  // Operand extension
  logic                            sign_a;
  logic                            sign_b;
  logic signed [ex_pkg::DATA_W:0]  op_a_ext;
  logic signed [ex_pkg::DATA_W:0]  op_b_ext;

  // 66-bit signed product of the extended operands
  logic signed [2*ex_pkg::DATA_W+1:0] product;

  logic          is_high;
  ex_pkg::data_t mulh_q;

  //////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////

  // MUL_H signs both, MUL_HSU signs only a
  assign sign_a = (operator_i == ex_pkg::MUL_H) | (operator_i == ex_pkg::MUL_HSU);
  assign sign_b = (operator_i == ex_pkg::MUL_H);

  assign op_a_ext = {sign_a & op_a_i[ex_pkg::DATA_W-1], op_a_i};
  assign op_b_ext = {sign_b & op_b_i[ex_pkg::DATA_W-1], op_b_i};

  assign product = op_a_ext * op_b_ext;

  assign is_high = enable_i & (operator_i != ex_pkg::MUL_L);

  //////////////////////////////////////////////////
  // High-word sequencer
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;

    case (state_q)
      IDLE: begin
        // First cycle of a high multiply stalls the stage
        if (is_high) begin
          ready_o      = 1'b0;
          multicycle_o = 1'b1;
          state_d      = STEP;
        end
      end
      STEP: begin
        // Result sits in mulh_q until the stage moves on
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper word captured in the stall cycle
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && is_high) begin
      mulh_q <= product[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W];
    end
  end

  // Low word is the same for every sign mode
  assign result_o = (state_q == STEP) ? mulh_q : product[ex_pkg::DATA_W-1:0];

endmodule

//--- verilog/ex_pkg.sv
package ex_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Operand and result width
  localparam int DATA_W = 32;
  // Register file address width, upper bit selects the FP bank
  localparam int RADDR_W = 6;

  // Operand or result word
  typedef logic [DATA_W-1:0] data_t;
  // Register file write address
  typedef logic [RADDR_W-1:0] raddr_t;

  //////////////////////////////////////////////////
  // Operator encodings
  //////////////////////////////////////////////////

  // ALU operators, all sixteen codes are in use
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch comparisons
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_L   = 2'b00,
    MUL_H   = 2'b01,
    MUL_HSU = 2'b10,
    MUL_HU  = 2'b11
  } mul_op_e;

endpackage

//--- verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
  parameter int unsigned POWER_GATE = 1
) (
  input  logic            clk,
  input  logic            rst_n,

  // ALU operation from ID
  input  logic            alu_en_i,
  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::data_t   alu_operand_a_i,
  input  ex_pkg::data_t   alu_operand_b_i,
  input  ex_pkg::data_t   alu_operand_c_i,

  // Multiplier operation from ID
  input  logic            mult_en_i,
  input  ex_pkg::mul_op_e mult_operator_i,
  input  ex_pkg::data_t   mult_operand_a_i,
  input  ex_pkg::data_t   mult_operand_b_i,

  input  logic            csr_access_i,
  input  ex_pkg::data_t   csr_rdata_i,

  // Load/store unit
  input  logic            lsu_en_i,
  input  ex_pkg::data_t   lsu_rdata_i,
  input  logic            lsu_ready_ex_i,
  input  logic            lsu_err_i,

  input  logic            branch_in_ex_i,
  input  logic            wb_ready_i,

  input  logic            regfile_alu_we_i,
  input  ex_pkg::raddr_t  regfile_alu_waddr_i,
  input  logic            regfile_we_i,
  input  ex_pkg::raddr_t  regfile_waddr_i,

  // Forwarding port
  output ex_pkg::raddr_t  regfile_alu_waddr_fw_o,
  output logic            regfile_alu_we_fw_o,
  output logic            regfile_alu_we_fw_power_o,
  output ex_pkg::data_t   regfile_alu_wdata_fw_o,

  // Load write-back port
  output ex_pkg::raddr_t  regfile_waddr_wb_o,
  output logic            regfile_we_wb_o,
  output logic            regfile_we_wb_power_o,
  output ex_pkg::data_t   regfile_wdata_wb_o,

  output logic            ex_ready_o,
  output logic            ex_valid_o,
  output logic            mult_multicycle_o,

  // To IF
  output logic            branch_decision_o,
  output ex_pkg::data_t   jump_target_o
);

  ex_pkg::data_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::data_t mult_result;
  logic          mult_ready;

  // Branch target is computed in ID and passed on operand c
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .alu_en_i     (alu_en_i),
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  //////////////////////////////////////////////////
  // Write-back and stage control
  //////////////////////////////////////////////////

  ex_writeback #(
    .POWER_GATE (POWER_GATE)
  ) u_writeback (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .alu_en_i                  (alu_en_i),
    .mult_en_i                 (mult_en_i),
    .csr_access_i              (csr_access_i),
    .lsu_en_i                  (lsu_en_i),
    .alu_result_i              (alu_result),
    .mult_result_i             (mult_result),
    .csr_rdata_i               (csr_rdata_i),
    .lsu_rdata_i               (lsu_rdata_i),
    .mult_ready_i              (mult_ready),
    .lsu_ready_ex_i            (lsu_ready_ex_i),
    .lsu_err_i                 (lsu_err_i),
    .wb_ready_i                (wb_ready_i),
    .branch_in_ex_i            (branch_in_ex_i),
    .regfile_alu_we_i          (regfile_alu_we_i),
    .regfile_we_i              (regfile_we_i),
    .regfile_alu_waddr_i       (regfile_alu_waddr_i),
    .regfile_waddr_i           (regfile_waddr_i),
    .regfile_alu_waddr_fw_o    (regfile_alu_waddr_fw_o),
    .regfile_alu_we_fw_o       (regfile_alu_we_fw_o),
    .regfile_alu_we_fw_power_o (regfile_alu_we_fw_power_o),
    .regfile_alu_wdata_fw_o    (regfile_alu_wdata_fw_o),
    .regfile_waddr_wb_o        (regfile_waddr_wb_o),
    .regfile_we_wb_o           (regfile_we_wb_o),
    .regfile_we_wb_power_o     (regfile_we_wb_power_o),
    .regfile_wdata_wb_o        (regfile_wdata_wb_o),
    .ex_ready_o                (ex_ready_o),
    .ex_valid_o                (ex_valid_o)
  );

endmodule

//--- verilog/ex_writeback.sv
`timescale 1ns/1ps

module ex_writeback #(
  parameter int unsigned POWER_GATE = 1
) (
  input  logic           clk,
  input  logic           rst_n,

  // Unit enables from ID
  input  logic           alu_en_i,
  input  logic           mult_en_i,
  input  logic           csr_access_i,
  input  logic           lsu_en_i,

  // Result sources
  input  ex_pkg::data_t  alu_result_i,
  input  ex_pkg::data_t  mult_result_i,
  input  ex_pkg::data_t  csr_rdata_i,
  input  ex_pkg::data_t  lsu_rdata_i,

  // Stall and flow control
  input  logic           mult_ready_i,
  input  logic           lsu_ready_ex_i,
  input  logic           lsu_err_i,
  input  logic           wb_ready_i,
  input  logic           branch_in_ex_i,

  // Destination registers
  input  logic           regfile_alu_we_i,
  input  logic           regfile_we_i,
  input  ex_pkg::raddr_t regfile_alu_waddr_i,
  input  ex_pkg::raddr_t regfile_waddr_i,

  // Forwarding port back to ID
  output ex_pkg::raddr_t regfile_alu_waddr_fw_o,
  output logic           regfile_alu_we_fw_o,
  output logic           regfile_alu_we_fw_power_o,
  output ex_pkg::data_t  regfile_alu_wdata_fw_o,

  // Load write-back port
  output ex_pkg::raddr_t regfile_waddr_wb_o,
  output logic           regfile_we_wb_o,
  output logic           regfile_we_wb_power_o,
  output ex_pkg::data_t  regfile_wdata_wb_o,

  output logic           ex_ready_o,
  output logic           ex_valid_o
);

  logic           regfile_we_lsu_q;
  ex_pkg::raddr_t regfile_waddr_lsu_q;
  logic           lsu_we;
  logic           units_ready;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  // CSR wins over the multiplier, which wins over the ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;

  // Only toggle the RF write while the producing units are done
  assign regfile_alu_we_fw_power_o = (POWER_GATE != 0) ?
                                     regfile_alu_we_i & mult_ready_i & lsu_ready_ex_i :
                                     regfile_alu_we_i;

  //////////////////////////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////////////////////////

  // A bus error cancels the load write
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_lsu_q <= lsu_we;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, flush the slot
      regfile_we_lsu_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && lsu_we) begin
      regfile_waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = regfile_we_lsu_q;
  assign regfile_waddr_wb_o = regfile_waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;

  assign regfile_we_wb_power_o = (POWER_GATE != 0) ? regfile_we_lsu_q & wb_ready_i :
                                                     regfile_we_lsu_q;

  //////////////////////////////////////////////////
  // Stage ready and valid
  //////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX and never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule
